// File: source/hatch_pkg.sv
// game state type and embryo, cold and stage constants for the incubation game
package hatch_pkg;

    // incubation game states
    typedef enum logic [2:0]
    {
        st_idle    = 3'd0,
        st_ready   = 3'd1,
        st_early   = 3'd2,
        st_late    = 3'd3,
        st_hatched = 3'd4,
        st_failed  = 3'd5
    } hatch_state_t;

    // stage where the heater stops mattering
    localparam logic [4:0] EMBRYO_LATE = 5'd10;

    // stage that means the egg has hatched
    localparam logic [4:0] EMBRYO_DONE = 5'd16;

    // consecutive cold seconds that kill the egg
    localparam logic [2:0] COLD_LIMIT = 3'd5;

    // game seconds per embryo stage
    localparam logic [1:0] SECONDS_PER_STAGE = 2'd2;

endpackage

// File: source/input_decode.sv
// switch synchroniser, btn0 debouncer with press strobe, and game second tick divider
`timescale 1ns/1ps

module input_decode
#(
    parameter int TICK_DIV     = 50_000_000,
    parameter int DEBOUNCE_LEN = 1_000_000
)
(
    input  logic clk,
    input  logic sw7,
    input  logic btn0,
    input  logic sw0,
    output logic press,
    output logic heat,
    output logic tick
);

    localparam int CW = $clog2(DEBOUNCE_LEN + 1);
    localparam int TW = $clog2(TICK_DIV + 1);

    logic          btn_meta;
    logic          btn_sync;
    logic          sw0_meta;
    logic [CW-1:0] stable_cnt;
    logic          btn_level;
    logic          btn_level_d;
    logic [TW-1:0] div_cnt;

    // two-flop synchronisers, heat is the second sw0 stage
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            sw0_meta <= 1'b0;
            heat     <= 1'b0;
        end
        else
        begin
            btn_meta <= btn0;
            btn_sync <= btn_meta;
            sw0_meta <= sw0;
            heat     <= sw0_meta;
        end
    end

    // new button level only after DEBOUNCE_LEN differing samples in a row
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            stable_cnt  <= '0;
            btn_level   <= 1'b0;
            btn_level_d <= 1'b0;
            press       <= 1'b0;
        end
        else
        begin
            if (btn_sync == btn_level)
                stable_cnt <= '0;
            else if (stable_cnt == CW'(DEBOUNCE_LEN - 1))
            begin
                btn_level  <= btn_sync;
                stable_cnt <= '0;
            end
            else
                stable_cnt <= stable_cnt + 1'b1;
            // rising edge of the accepted level
            btn_level_d <= btn_level;
            press       <= btn_level & ~btn_level_d;
        end
    end

    // free running divider, one strobe per game second
    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end
        else if (div_cnt == TW'(TICK_DIV - 1))
        begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

// File: source/hatch_execute.sv
// incubation FSM with embryo stage, cold seconds and elapsed seconds counters
`timescale 1ns/1ps

module hatch_execute
    import hatch_pkg::*;
(
    input  logic         clk,
    input  logic         sw7,
    input  logic         press,
    input  logic         heat,
    input  logic         tick,
    output hatch_state_t state,
    output logic [4:0]   embryo,
    output logic [3:0]   secs_tens,
    output logic [3:0]   secs_ones
);

    hatch_state_t state_nxt;
    logic [4:0]   embryo_nxt;
    logic [3:0]   tens_nxt;
    logic [3:0]   ones_nxt;
    logic [2:0]   cold;
    logic [2:0]   cold_nxt;
    logic         phase;
    logic         phase_nxt;
    logic         stage_adv;

    // embryo moves on the last second of each stage period
    assign stage_adv = ({1'b0, phase} == SECONDS_PER_STAGE - 2'd1);

    always_comb
    begin
        state_nxt  = state;
        embryo_nxt = embryo;
        tens_nxt   = secs_tens;
        ones_nxt   = secs_ones;
        cold_nxt   = cold;
        phase_nxt  = phase;
        case (state)
            st_idle:
                state_nxt = st_ready;
            st_ready:
            begin
                if (press)
                begin
                    state_nxt  = st_early;
                    embryo_nxt = '0;
                    tens_nxt   = '0;
                    ones_nxt   = '0;
                    cold_nxt   = '0;
                    phase_nxt  = 1'b0;
                end
            end
            st_early, st_late:
            begin
                if (tick)
                begin
                    // seconds in two decimal digits, wrap at 99
                    if (secs_ones == 4'd9)
                    begin
                        ones_nxt = 4'd0;
                        tens_nxt = (secs_tens == 4'd9) ? 4'd0 : secs_tens + 4'd1;
                    end
                    else
                        ones_nxt = secs_ones + 4'd1;
                    if (stage_adv)
                    begin
                        embryo_nxt = embryo + 5'd1;
                        phase_nxt  = 1'b0;
                    end
                    else
                        phase_nxt = phase + 1'b1;
                    if (state == st_early)
                    begin
                        cold_nxt = heat ? 3'd0 : cold + 3'd1;
                        // reaching the late stage beats a cold failure
                        if (embryo_nxt == EMBRYO_LATE)
                            state_nxt = st_late;
                        else if (cold_nxt == COLD_LIMIT)
                            state_nxt = st_failed;
                    end
                    else if (embryo_nxt == EMBRYO_DONE)
                        state_nxt = st_hatched;
                end
            end
            st_hatched, st_failed:
            begin
                if (press)
                    state_nxt = st_ready;
            end
            default:
                state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            state     <= st_idle;
            embryo    <= '0;
            secs_tens <= '0;
            secs_ones <= '0;
            cold      <= '0;
            phase     <= 1'b0;
        end
        else
        begin
            state     <= state_nxt;
            embryo    <= embryo_nxt;
            secs_tens <= tens_nxt;
            secs_ones <= ones_nxt;
            cold      <= cold_nxt;
            phase     <= phase_nxt;
        end
    end

endmodule

// File: source/display_result.sv
// seven-segment digit scan, LED matrix row scan with egg patterns, status LEDs
`timescale 1ns/1ps

module display_result
    import hatch_pkg::*;
#(
    parameter int SCAN_DIV = 50_000
)
(
    input  logic         clk,
    input  logic         sw7,
    input  hatch_state_t state,
    input  logic [4:0]   embryo,
    input  logic [3:0]   secs_tens,
    input  logic [3:0]   secs_ones,
    output logic [7:0]   seg,
    output logic [7:0]   dig,
    output logic [7:0]   row,
    output logic [7:0]   colg,
    output logic [7:0]   colr,
    output logic         led0,
    output logic         led2
);

    localparam int DW = $clog2(SCAN_DIV + 1);

    logic [DW-1:0] div_cnt;
    logic [2:0]    scan;
    logic [3:0]    emb_tens;
    logic [3:0]    emb_ones;
    logic [3:0]    digit_val;

    // active high segments g..a for one decimal digit
    function automatic logic [6:0] seg_decode(input logic [3:0] val);
        case (val)
            4'd0:    seg_decode = 7'h3f;
            4'd1:    seg_decode = 7'h06;
            4'd2:    seg_decode = 7'h5b;
            4'd3:    seg_decode = 7'h4f;
            4'd4:    seg_decode = 7'h66;
            4'd5:    seg_decode = 7'h6d;
            4'd6:    seg_decode = 7'h7d;
            4'd7:    seg_decode = 7'h07;
            4'd8:    seg_decode = 7'h7f;
            4'd9:    seg_decode = 7'h6f;
            default: seg_decode = 7'h00;
        endcase
    endfunction

    // egg outline, one byte per row
    function automatic logic [7:0] egg_row(input logic [2:0] r);
        case (r)
            3'd0:    egg_row = 8'h18;
            3'd1:    egg_row = 8'h24;
            3'd2,
            3'd3:    egg_row = 8'h42;
            3'd4,
            3'd5:    egg_row = 8'h81;
            3'd6:    egg_row = 8'h42;
            default: egg_row = 8'h3c;
        endcase
    endfunction

    // first n pixels lit row-major, this row's slice
    function automatic logic [7:0] fill_row(input logic [2:0] r, input logic [4:0] n);
        logic [6:0] pix;
        for (int b = 0; b < 8; b++)
        begin
            pix         = {1'b0, r, 3'b000} + 7'(b);
            fill_row[b] = (pix < {2'b00, n});
        end
    endfunction

    // split embryo into decimal digits
    always_comb
    begin
        if (embryo >= 5'd30)
            emb_tens = 4'd3;
        else if (embryo >= 5'd20)
            emb_tens = 4'd2;
        else if (embryo >= 5'd10)
            emb_tens = 4'd1;
        else
            emb_tens = 4'd0;
        emb_ones = 4'(embryo - 5'(emb_tens * 4'd10));
        case (scan[1:0])
            2'd0:    digit_val = emb_ones;
            2'd1:    digit_val = emb_tens;
            2'd2:    digit_val = secs_ones;
            default: digit_val = secs_tens;
        endcase
    end

    always_ff @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            div_cnt <= '0;
            scan    <= '0;
            seg     <= 8'hff;
            dig     <= 8'hff;
            row     <= 8'hff;
            colg    <= 8'h00;
            colr    <= 8'h00;
            led0    <= 1'b0;
            led2    <= 1'b0;
        end
        else
        begin
            if (div_cnt == DW'(SCAN_DIV - 1))
            begin
                div_cnt <= '0;
                scan    <= scan + 3'd1;
            end
            else
                div_cnt <= div_cnt + 1'b1;
            led0 <= (state == st_hatched);
            led2 <= (state == st_failed);
            if (state == st_idle)
            begin
                seg  <= 8'hff;
                dig  <= 8'hff;
                row  <= 8'hff;
                colg <= 8'h00;
                colr <= 8'h00;
            end
            else
            begin
                // decimal point stays off
                seg <= ~{1'b0, seg_decode(digit_val)};
                dig <= ~(8'h01 << scan[1:0]);
                row <= ~(8'h01 << scan);
                case (state)
                    st_ready:   colg <= egg_row(scan);
                    st_hatched: colg <= 8'hff;
                    st_failed:  colg <= 8'h00;
                    default:    colg <= fill_row(scan, embryo);
                endcase
                colr <= (state == st_failed) ? 8'hff : 8'h00;
            end
        end
    end

endmodule

// File: source/eggs_hatch_top.sv
// top level wiring input decode, incubation FSM and display with board timing
`timescale 1ns/1ps

module eggs_hatch_top
    import hatch_pkg::*;
#(
    parameter int TICK_DIV     = 50_000_000,
    parameter int DEBOUNCE_LEN = 1_000_000,
    parameter int SCAN_DIV     = 50_000
)
(
    input  logic       clk,
    input  logic       sw7,
    input  logic       btn0,
    input  logic       sw0,
    output logic       led0,
    output logic       led2,
    output logic [7:0] row,
    output logic [7:0] colg,
    output logic [7:0] colr,
    output logic [7:0] seg,
    output logic [7:0] dig
);

    logic         press;
    logic         heat;
    logic         tick;
    hatch_state_t state;
    logic [4:0]   embryo;
    logic [3:0]   secs_tens;
    logic [3:0]   secs_ones;

    // debounced press, synchronised heater, one second tick
    input_decode
    #(
        .TICK_DIV     (TICK_DIV),
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    )
    u_decode
    (
        .clk   (clk),
        .sw7   (sw7),
        .btn0  (btn0),
        .sw0   (sw0),
        .press (press),
        .heat  (heat),
        .tick  (tick)
    );

    hatch_execute u_execute
    (
        .clk       (clk),
        .sw7       (sw7),
        .press     (press),
        .heat      (heat),
        .tick      (tick),
        .state     (state),
        .embryo    (embryo),
        .secs_tens (secs_tens),
        .secs_ones (secs_ones)
    );

    // matrix, digits and status LEDs
    display_result
    #(
        .SCAN_DIV (SCAN_DIV)
    )
    u_result
    (
        .clk       (clk),
        .sw7       (sw7),
        .state     (state),
        .embryo    (embryo),
        .secs_tens (secs_tens),
        .secs_ones (secs_ones),
        .seg       (seg),
        .dig       (dig),
        .row       (row),
        .colg      (colg),
        .colr      (colr),
        .led0      (led0),
        .led2      (led2)
    );

endmodule

// File: verification/tb_eggs_hatch.sv
// testbench for eggs_hatch_top with LFSR stimulus, reference model and output checks
`timescale 1ns/1ps

module tb_eggs_hatch;

    localparam int TICK_DIV       = 40;
    localparam int DEBOUNCE_LEN   = 4;
    localparam int SCAN_DIV       = 1;
    localparam int STAGE_LATE     = 10;
    localparam int STAGE_DONE     = 16;
    localparam int COLD_MAX       = 5;
    localparam int SECS_PER_STAGE = 2;
    localparam int GAMES          = 20;
    localparam int GAME_SECS      = 20;
    localparam int TIMEOUT_CYCLES = GAMES * GAME_SECS * TICK_DIV + 2000;

    // model states
    localparam int M_IDLE    = 0;
    localparam int M_READY   = 1;
    localparam int M_EARLY   = 2;
    localparam int M_LATE    = 3;
    localparam int M_HATCHED = 4;
    localparam int M_FAILED  = 5;

    logic       clk;
    logic       sw7;
    logic       btn0;
    logic       sw0;
    logic       led0;
    logic       led2;
    logic [7:0] row;
    logic [7:0] colg;
    logic [7:0] colr;
    logic [7:0] seg;
    logic [7:0] dig;

    logic [31:0] lfsr = 32'hdf92;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          hatched = 0;
    int          failed = 0;

    // reference model state
    int         m_state;
    int         m_embryo;
    int         m_secs;
    int         m_cold;
    int         m_phase;
    int         m_cnt;
    int         m_hi_run;
    int         m_scan;
    int         m_div;
    logic       m_sw0_q;
    logic       m_heat;
    logic [3:0] m_press_pipe;
    logic       tick_now;
    logic       press_now;
    logic       heat_now;

    // expected registered outputs
    logic [7:0] e_seg;
    logic [7:0] e_dig;
    logic [7:0] e_row;
    logic [7:0] e_colg;
    logic [7:0] e_colr;
    logic       e_led0;
    logic       e_led2;
    logic       e_outline;
    logic       armed = 1'b0;

    eggs_hatch_top
    #(
        .TICK_DIV     (TICK_DIV),
        .DEBOUNCE_LEN (DEBOUNCE_LEN),
        .SCAN_DIV     (SCAN_DIV)
    )
    UUT
    (
        .clk  (clk),
        .sw7  (sw7),
        .btn0 (btn0),
        .sw0  (sw0),
        .led0 (led0),
        .led2 (led2),
        .row  (row),
        .colg (colg),
        .colr (colr),
        .seg  (seg),
        .dig  (dig)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois LFSR stepped once per bit
    function automatic logic take_bit();
        logic out;
        out  = lfsr[0];
        lfsr = out ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
        return out;
    endfunction

    function automatic int random_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++)
        begin
            v = v << 1;
            if (take_bit())
                v = v + 1;
        end
        return v;
    endfunction

    // common anode codes with the decimal point off
    function automatic logic [7:0] seg_code(input int d);
        case (d)
            0:       return 8'hc0;
            1:       return 8'hf9;
            2:       return 8'ha4;
            3:       return 8'hb0;
            4:       return 8'h99;
            5:       return 8'h92;
            6:       return 8'h82;
            7:       return 8'hf8;
            8:       return 8'h80;
            default: return 8'h90;
        endcase
    endfunction

    task check_value(input logic [31:0] got, input logic [31:0] expected, input string what);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("[ERROR] %0t ns: %s got %0h expected %0h", $time, what, got, expected);
        end
    endtask

    task model_reset();
        m_state      = M_IDLE;
        m_embryo     = 0;
        m_secs       = 0;
        m_cold       = 0;
        m_phase      = 0;
        m_cnt        = 0;
        m_hi_run     = 0;
        m_scan       = 0;
        m_div        = 0;
        m_sw0_q      = 1'b0;
        m_heat       = 1'b0;
        m_press_pipe = 4'h0;
        e_seg        = 8'hff;
        e_dig        = 8'hff;
        e_row        = 8'hff;
        e_colg       = 8'h00;
        e_colr       = 8'h00;
        e_led0       = 1'b0;
        e_led2       = 1'b0;
        e_outline    = 1'b0;
    endtask

    // what the display registers take from the current model state
    task expect_outputs();
        int digit;
        int b;
        e_outline = 1'b0;
        e_colg    = 8'h00;
        e_colr    = 8'h00;
        e_led0    = (m_state == M_HATCHED);
        e_led2    = (m_state == M_FAILED);
        if (m_state == M_IDLE)
        begin
            e_seg = 8'hff;
            e_dig = 8'hff;
            e_row = 8'hff;
        end
        else
        begin
            case (m_scan % 4)
                0:       digit = m_embryo % 10;
                1:       digit = m_embryo / 10;
                2:       digit = m_secs % 10;
                default: digit = m_secs / 10;
            endcase
            e_seg = seg_code(digit);
            e_dig = ~(8'h01 << (m_scan % 4));
            e_row = ~(8'h01 << m_scan);
            if (m_state == M_READY)
                e_outline = 1'b1;
            else if (m_state == M_HATCHED)
                e_colg = 8'hff;
            else if (m_state == M_FAILED)
                e_colr = 8'hff;
            else
                for (b = 0; b < 8; b++)
                    e_colg[b] = (m_scan * 8 + b < m_embryo);
        end
    endtask

    task game_step();
        case (m_state)
            M_IDLE:
                m_state = M_READY;
            M_READY:
            begin
                if (press_now)
                begin
                    m_state  = M_EARLY;
                    m_embryo = 0;
                    m_secs   = 0;
                    m_cold   = 0;
                    m_phase  = 0;
                end
            end
            M_EARLY, M_LATE:
            begin
                if (tick_now)
                begin
                    m_secs  = (m_secs + 1) % 100;
                    m_phase = m_phase + 1;
                    if (m_phase == SECS_PER_STAGE)
                    begin
                        m_phase  = 0;
                        m_embryo = m_embryo + 1;
                    end
                    if (m_state == M_EARLY)
                    begin
                        m_cold = heat_now ? 0 : m_cold + 1;
                        // reaching late growth wins over the cold limit
                        if (m_embryo == STAGE_LATE)
                            m_state = M_LATE;
                        else if (m_cold == COLD_MAX)
                            m_state = M_FAILED;
                    end
                    else if (m_embryo == STAGE_DONE)
                        m_state = M_HATCHED;
                end
            end
            default:
            begin
                if (press_now)
                    m_state = M_READY;
            end
        endcase
    endtask

    // cycle model of the input timing, the FSM and the display scan
    always @(posedge clk or negedge sw7)
    begin
        if (!sw7)
        begin
            model_reset();
            armed = 1'b1;
        end
        else
        begin
            tick_now  = (m_cnt >= TICK_DIV) && (m_cnt % TICK_DIV == 0);
            press_now = m_press_pipe[3];
            heat_now  = m_heat;
            expect_outputs();
            m_cnt   = m_cnt + 1;
            m_heat  = m_sw0_q;
            m_sw0_q = sw0;
            if (btn0)
                m_hi_run = m_hi_run + 1;
            else
                m_hi_run = 0;
            // press seen four edges after the button has been high long enough
            m_press_pipe = {m_press_pipe[2:0], m_hi_run == DEBOUNCE_LEN};
            if (m_div == SCAN_DIV - 1)
            begin
                m_div  = 0;
                m_scan = (m_scan + 1) % 8;
            end
            else
                m_div = m_div + 1;
            game_step();
        end
    end

    always @(negedge clk)
    begin
        if (armed)
        begin
            check_value(32'(seg), 32'(e_seg), "seg");
            check_value(32'(dig), 32'(e_dig), "dig");
            check_value(32'(row), 32'(e_row), "row");
            check_value(32'(colr), 32'(e_colr), "colr");
            check_value(32'(led0), 32'(e_led0), "led0");
            check_value(32'(led2), 32'(e_led2), "led2");
            // any outline passes as long as each egg row has a lit pixel
            if (e_outline)
                check_value(32'(colg != 8'h00), 1, "egg outline row lit");
            else
                check_value(32'(colg), 32'(e_colg), "colg");
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES)
        begin
            $display("timeout: no end of test after %0d cycles, checks %0d errors %0d",
                     TIMEOUT_CYCLES, checks, errors);
            $display("Test FAILED");
            $finish;
        end
    end

    task press_button();
        int gap;
        gap = 20 + random_bits(4);
        repeat (gap) @(posedge clk);
        btn0 <= 1'b1;
        repeat (10) @(posedge clk);
        btn0 <= 1'b0;
        repeat (20) @(posedge clk);
    endtask

    // short pulse below the debounce length
    task glitch_button();
        int gap;
        gap = 20 + random_bits(3);
        repeat (gap) @(posedge clk);
        btn0 <= 1'b1;
        repeat (3) @(posedge clk);
        btn0 <= 1'b0;
        repeat (20) @(posedge clk);
    endtask

    // mode 0 warm, mode 1 fair coin, mode 2 mostly cold, late growth always cold
    task run_game(input int mode);
        int   n;
        logic done;
        logic late;
        logic hot;
        n    = 0;
        done = 1'b0;
        late = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            if (n == 0)
            begin
                if (mode == 0)
                    hot = 1'b1;
                else if (late)
                    hot = 1'b0;
                else if (mode == 1)
                    hot = take_bit();
                else
                begin
                    hot = take_bit();
                    hot = hot & take_bit();
                end
                sw0 <= hot;
            end
            n = (n + 1) % TICK_DIV;
            @(negedge clk);
            done = led0 || led2;
            late = (m_state == M_LATE);
        end
        if (led0)
            hatched++;
        else
            failed++;
    endtask

    initial
    begin
        int g;
        sw7  = 1'b0;
        btn0 = 1'b0;
        sw0  = 1'b0;
        repeat (4) @(posedge clk);
        sw7 <= 1'b1;

        // glitches in ready must not start a game
        repeat (3) glitch_button();
        @(negedge clk);
        check_value(32'(colg != 8'h00), 1, "egg outline after glitches");

        // warm game runs to a hatch
        press_button();
        run_game(0);
        check_value(32'(led0), 1, "led0 after a warm game");
        press_button();
        @(negedge clk);
        check_value(32'(led0 | led2), 0, "status LEDs back in ready");

        for (g = 0; g < 8; g++)
        begin
            press_button();
            run_game(1 + g % 2);
            press_button();
        end

        // reset in the middle of growth
        press_button();
        sw0 <= 1'b1;
        repeat (6 * TICK_DIV) @(posedge clk);
        sw7 <= 1'b0;
        repeat (4) @(posedge clk);
        sw7 <= 1'b1;
        repeat (2) @(posedge clk);
        press_button();
        run_game(0);
        press_button();

        check_value(32'(hatched > 0), 1, "some game hatched");
        check_value(32'(failed > 0), 1, "some game failed");
        repeat (4) @(posedge clk);
        $display("checks %0d errors %0d hatched %0d failed %0d",
                 checks, errors, hatched, failed);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: filelist.f
source/hatch_pkg.sv
source/input_decode.sv
source/hatch_execute.sv
source/display_result.sv
source/eggs_hatch_top.sv
verification/tb_eggs_hatch.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing
TOP       = tb_eggs_hatch
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
